/* tile_cfg.svh */
`ifndef TILE_CFG_SVH
`define TILE_CFG_SVH

// Bits held by one buffer of a buffer file
`define TILE_BUFFER_WIDTH 1024

// Bits per tile, also the width of one host write
`define TILE_WIDTH 256

// Bits per element and elements per tile
`define TILE_DATA_WIDTH 8
`define TILE_SIZE 32

// Buffers per buffer file, two gives double buffering
`define TILE_BUFFER_COUNT 2

// Accumulator and result width
`define TILE_ACC_WIDTH 32

// Tiles per buffer, derived
`define TILE_COUNT (`TILE_BUFFER_WIDTH / `TILE_WIDTH)

`endif

/* tile_pkg.sv */
`include "tile_cfg.svh"

package tile_pkg;

    // One signed byte of an activation or weight tile
    typedef logic signed [`TILE_DATA_WIDTH-1:0] elem_t;

    // Signed accumulator, also the engine result
    typedef logic signed [`TILE_ACC_WIDTH-1:0] acc_t;

    // Raw dot product, or dot product with negative sums clamped to zero
    typedef enum logic [0:0] {
        OP_DOT      = 1'b0,
        OP_DOT_RELU = 1'b1
    } op_e;

    typedef enum logic [1:0] {
        SEQ_IDLE   = 2'd0,
        SEQ_STROBE = 2'd1,
        SEQ_GAP    = 2'd2,
        SEQ_DRAIN  = 2'd3
    } seq_state_e;

endpackage

/* buffer_file.sv */
`timescale 1ns/100ps

module buffer_file #(
    parameter int BUFFER_WIDTH = 1024,
    parameter int BUFFER_COUNT = 2,
    parameter int TILE_WIDTH   = 256,
    parameter int DATA_WIDTH   = 8,
    parameter int TILE_SIZE    = 32
) (
    input  logic                            clk,
    input  logic                            reset_n,
    input  logic                            write_enable,
    input  logic                            read_enable,
    input  logic [TILE_WIDTH-1:0]           write_data,
    input  logic [$clog2(BUFFER_COUNT)-1:0] write_buffer,
    input  logic [$clog2(BUFFER_COUNT)-1:0] read_buffer,
    output logic signed [DATA_WIDTH-1:0]    read_data [TILE_SIZE],
    output logic                            writing_done,
    output logic                            reading_done,
    // Restart the tile indices of one buffer
    input  logic                            reset_indices_enable,
    input  logic [$clog2(BUFFER_COUNT)-1:0] reset_indices_buffer
);

    localparam int TILE_COUNT       = BUFFER_WIDTH / TILE_WIDTH;
    localparam int TILE_INDEX_WIDTH = (TILE_COUNT == 1) ? 1 : $clog2(TILE_COUNT);
    localparam logic [TILE_INDEX_WIDTH-1:0] LAST_TILE = TILE_INDEX_WIDTH'(TILE_COUNT - 1);

    logic [BUFFER_WIDTH-1:0] buffers [BUFFER_COUNT];

    // Next tile to write and to read, one pair per buffer
    logic [TILE_INDEX_WIDTH-1:0] w_tile_index [BUFFER_COUNT];
    logic [TILE_INDEX_WIDTH-1:0] r_tile_index [BUFFER_COUNT];

    logic [TILE_INDEX_WIDTH-1:0] eff_w_index;
    logic [TILE_INDEX_WIDTH-1:0] eff_r_index;

    logic read_enable_prev;
    logic read_rise;

    // A read happens only on the rising edge of read_enable
    assign read_rise = read_enable && !read_enable_prev;

    // Index restart takes effect in the same cycle as the access
    always_comb begin
        if (reset_indices_enable && reset_indices_buffer == write_buffer) begin
            eff_w_index = '0;
        end else begin
            eff_w_index = w_tile_index[write_buffer];
        end
        if (reset_indices_enable && reset_indices_buffer == read_buffer) begin
            eff_r_index = '0;
        end else begin
            eff_r_index = r_tile_index[read_buffer];
        end
    end

    // Tile storage and read port
    always_ff @(posedge clk) begin
        if (write_enable) begin
            buffers[write_buffer][eff_w_index * TILE_WIDTH +: TILE_WIDTH] <= write_data;
        end
        if (read_rise) begin
            for (int i = 0; i < TILE_SIZE; i++) begin
                read_data[i] <=
                    buffers[read_buffer][eff_r_index * TILE_WIDTH + i * DATA_WIDTH +: DATA_WIDTH];
            end
        end
    end

    // Index bookkeeping and done pulses
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            read_enable_prev <= 1'b0;
            writing_done     <= 1'b0;
            reading_done     <= 1'b0;
            for (int i = 0; i < BUFFER_COUNT; i++) begin
                w_tile_index[i] <= '0;
                r_tile_index[i] <= '0;
            end
        end else begin
            read_enable_prev <= read_enable;
            writing_done     <= 1'b0;
            reading_done     <= 1'b0;

            if (write_enable) begin
                if (eff_w_index == LAST_TILE) begin
                    w_tile_index[write_buffer] <= '0;
                    writing_done               <= 1'b1;
                end else begin
                    w_tile_index[write_buffer] <= eff_w_index + 1'b1;
                end
            end

            if (read_rise) begin
                if (eff_r_index == LAST_TILE) begin
                    r_tile_index[read_buffer] <= '0;
                    reading_done              <= 1'b1;
                end else begin
                    r_tile_index[read_buffer] <= eff_r_index + 1'b1;
                end
            end
        end
    end

    // Buffer selects must name an existing buffer whenever they are used
    assert property (@(posedge clk) disable iff (!reset_n)
        write_enable |-> write_buffer < BUFFER_COUNT)
    else $error("buffer_file: write_buffer %0d out of range", write_buffer);

    assert property (@(posedge clk) disable iff (!reset_n)
        read_rise |-> read_buffer < BUFFER_COUNT)
    else $error("buffer_file: read_buffer %0d out of range", read_buffer);

    assert property (@(posedge clk) disable iff (!reset_n)
        reset_indices_enable |-> reset_indices_buffer < BUFFER_COUNT)
    else $error("buffer_file: reset_indices_buffer %0d out of range", reset_indices_buffer);

endmodule

/* tile_sequencer.sv */
`timescale 1ns/100ps
`include "tile_cfg.svh"

module tile_sequencer (
    input  logic                                 clk,
    input  logic                                 reset_n,
    input  logic                                 start,
    input  logic [$clog2(`TILE_BUFFER_COUNT)-1:0] act_buffer,
    input  logic [$clog2(`TILE_BUFFER_COUNT)-1:0] wgt_buffer,
    input  logic                                 act_reading_done,
    input  logic                                 wgt_reading_done,
    output logic                                 read_enable,
    output logic                                 reset_indices_enable,
    output logic [$clog2(`TILE_BUFFER_COUNT)-1:0] act_read_buffer,
    output logic [$clog2(`TILE_BUFFER_COUNT)-1:0] wgt_read_buffer,
    output logic                                 tile_valid,
    output logic                                 tile_last,
    output logic                                 busy
);

    import tile_pkg::*;

    localparam int CNT_WIDTH = (`TILE_COUNT == 1) ? 1 : $clog2(`TILE_COUNT);
    localparam logic [CNT_WIDTH-1:0] LAST_STROBE = CNT_WIDTH'(`TILE_COUNT - 1);

    seq_state_e state;
    seq_state_e state_next;

    // Strobes issued so far in this run
    logic [CNT_WIDTH-1:0] strobe_cnt;
    logic                 start_accept;

    assign start_accept = start && (state == SEQ_IDLE);

    always_comb begin
        state_next = state;
        case (state)
            SEQ_IDLE: begin
                // Low half of the pattern comes first
                if (start) begin
                    state_next = SEQ_GAP;
                end
            end
            SEQ_GAP: begin
                state_next = SEQ_STROBE;
            end
            SEQ_STROBE: begin
                if (strobe_cnt == LAST_STROBE) begin
                    state_next = SEQ_DRAIN;
                end else begin
                    state_next = SEQ_GAP;
                end
            end
            SEQ_DRAIN: begin
                // Last tile is in, dot unit closes the sum on this edge
                if (act_reading_done) begin
                    state_next = SEQ_IDLE;
                end
            end
            default: begin
                state_next = SEQ_IDLE;
            end
        endcase
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            state           <= SEQ_IDLE;
            strobe_cnt      <= '0;
            act_read_buffer <= '0;
            wgt_read_buffer <= '0;
            tile_valid      <= 1'b0;
        end else begin
            state      <= state_next;
            // Data returns one edge after each strobe
            tile_valid <= read_enable;
            if (start_accept) begin
                strobe_cnt      <= '0;
                act_read_buffer <= act_buffer;
                wgt_read_buffer <= wgt_buffer;
            end else if (state == SEQ_STROBE) begin
                strobe_cnt <= strobe_cnt + 1'b1;
            end
        end
    end

    assign read_enable          = (state == SEQ_STROBE);
    assign reset_indices_enable = (state == SEQ_STROBE) && (strobe_cnt == '0);
    assign tile_last            = act_reading_done;
    assign busy                 = (state != SEQ_IDLE);

    // Both buffer files walk the same number of tiles in lockstep
    assert property (@(posedge clk) disable iff (!reset_n)
        act_reading_done == wgt_reading_done)
    else $error("tile_sequencer: activation and weight reads out of step");

    // A start during a run never begins a new run
    assert property (@(posedge clk) disable iff (!reset_n)
        (start && busy) |=> !(state == SEQ_GAP && strobe_cnt == '0))
    else $error("tile_sequencer: start accepted while busy");

endmodule

/* tile_dot_unit.sv */
`timescale 1ns/100ps
`include "tile_cfg.svh"

module tile_dot_unit (
    input  logic           clk,
    input  logic           reset_n,
    input  logic           start,
    input  logic           busy,
    input  tile_pkg::op_e  op,
    input  tile_pkg::elem_t act_tile [`TILE_SIZE],
    input  tile_pkg::elem_t wgt_tile [`TILE_SIZE],
    input  logic           tile_valid,
    input  logic           tile_last,
    output tile_pkg::acc_t result,
    output logic           result_valid
);

    import tile_pkg::*;

    op_e  op_q;
    acc_t acc;
    acc_t tile_sum;
    acc_t final_sum;
    acc_t clamped_sum;

    // Sum of the signed byte products of one tile pair
    always_comb begin
        tile_sum = '0;
        for (int i = 0; i < `TILE_SIZE; i++) begin
            tile_sum = tile_sum + act_tile[i] * wgt_tile[i];
        end
    end

    assign final_sum = acc + tile_sum;

    // ReLU only when the run asked for it
    always_comb begin
        if (op_q == OP_DOT_RELU && final_sum < 0) begin
            clamped_sum = '0;
        end else begin
            clamped_sum = final_sum;
        end
    end

    // Accumulator and operand capture
    always_ff @(posedge clk) begin
        if (start && !busy) begin
            op_q <= op;
            acc  <= '0;
        end else if (tile_valid) begin
            acc <= final_sum;
        end
        if (tile_valid && tile_last) begin
            result <= clamped_sum;
        end
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            result_valid <= 1'b0;
        end else begin
            result_valid <= tile_valid && tile_last;
        end
    end

endmodule

/* tile_engine.sv */
`timescale 1ns/100ps
`include "tile_cfg.svh"

module tile_engine (
    input  logic                                  clk,
    input  logic                                  reset_n,
    // Host writes into the activation buffers
    input  logic                                  act_write_enable,
    input  logic [`TILE_WIDTH-1:0]                act_write_data,
    input  logic [$clog2(`TILE_BUFFER_COUNT)-1:0] act_write_buffer,
    // Host writes into the weight buffers
    input  logic                                  wgt_write_enable,
    input  logic [`TILE_WIDTH-1:0]                wgt_write_data,
    input  logic [$clog2(`TILE_BUFFER_COUNT)-1:0] wgt_write_buffer,
    output logic                                  act_writing_done,
    output logic                                  wgt_writing_done,
    // Run control
    input  logic                                  start,
    input  tile_pkg::op_e                         op,
    input  logic [$clog2(`TILE_BUFFER_COUNT)-1:0] act_buffer,
    input  logic [$clog2(`TILE_BUFFER_COUNT)-1:0] wgt_buffer,
    output logic                                  busy,
    output logic                                  result_valid,
    output tile_pkg::acc_t                        result
);

    import tile_pkg::*;

    elem_t act_tile [`TILE_SIZE];
    elem_t wgt_tile [`TILE_SIZE];

    logic act_reading_done;
    logic wgt_reading_done;
    logic read_enable;
    logic reset_indices_enable;
    logic tile_valid;
    logic tile_last;

    logic [$clog2(`TILE_BUFFER_COUNT)-1:0] act_read_buffer;
    logic [$clog2(`TILE_BUFFER_COUNT)-1:0] wgt_read_buffer;

    buffer_file #(
        .BUFFER_WIDTH (`TILE_BUFFER_WIDTH),
        .BUFFER_COUNT (`TILE_BUFFER_COUNT),
        .TILE_WIDTH   (`TILE_WIDTH),
        .DATA_WIDTH   (`TILE_DATA_WIDTH),
        .TILE_SIZE    (`TILE_SIZE)
    ) i_act_buffers (
        .clk                  (clk),
        .reset_n              (reset_n),
        .write_enable         (act_write_enable),
        .read_enable          (read_enable),
        .write_data           (act_write_data),
        .write_buffer         (act_write_buffer),
        .read_buffer          (act_read_buffer),
        .read_data            (act_tile),
        .writing_done         (act_writing_done),
        .reading_done         (act_reading_done),
        .reset_indices_enable (reset_indices_enable),
        .reset_indices_buffer (act_read_buffer)
    );

    buffer_file #(
        .BUFFER_WIDTH (`TILE_BUFFER_WIDTH),
        .BUFFER_COUNT (`TILE_BUFFER_COUNT),
        .TILE_WIDTH   (`TILE_WIDTH),
        .DATA_WIDTH   (`TILE_DATA_WIDTH),
        .TILE_SIZE    (`TILE_SIZE)
    ) i_wgt_buffers (
        .clk                  (clk),
        .reset_n              (reset_n),
        .write_enable         (wgt_write_enable),
        .read_enable          (read_enable),
        .write_data           (wgt_write_data),
        .write_buffer         (wgt_write_buffer),
        .read_buffer          (wgt_read_buffer),
        .read_data            (wgt_tile),
        .writing_done         (wgt_writing_done),
        .reading_done         (wgt_reading_done),
        .reset_indices_enable (reset_indices_enable),
        .reset_indices_buffer (wgt_read_buffer)
    );

    // One strobe pattern drives both files in step
    tile_sequencer i_sequencer (
        .clk                  (clk),
        .reset_n              (reset_n),
        .start                (start),
        .act_buffer           (act_buffer),
        .wgt_buffer           (wgt_buffer),
        .act_reading_done     (act_reading_done),
        .wgt_reading_done     (wgt_reading_done),
        .read_enable          (read_enable),
        .reset_indices_enable (reset_indices_enable),
        .act_read_buffer      (act_read_buffer),
        .wgt_read_buffer      (wgt_read_buffer),
        .tile_valid           (tile_valid),
        .tile_last            (tile_last),
        .busy                 (busy)
    );

    tile_dot_unit i_dot_unit (
        .clk          (clk),
        .reset_n      (reset_n),
        .start        (start),
        .busy         (busy),
        .op           (op),
        .act_tile     (act_tile),
        .wgt_tile     (wgt_tile),
        .tile_valid   (tile_valid),
        .tile_last    (tile_last),
        .result       (result),
        .result_valid (result_valid)
    );

endmodule

/* tb_tile_engine.sv */
`timescale 1ns/100ps
`include "tile_cfg.svh"

module tb_tile_engine;

    import tile_pkg::*;

    localparam int CLK_PERIOD   = 40;
    localparam int RESET_CYCLES = 2;
    // Start edge to result_valid, fixed by the strobe/gap pattern
    localparam int RUN_CYCLES   = 2 * `TILE_COUNT + 1;
    localparam int RUN_LIMIT    = RUN_CYCLES + 8;
    localparam int QUIET_CYCLES = 12;
    // 36 tile writes of 3 cycles and 11 runs in the whole sequence, doubled
    localparam int WATCHDOG_CYCLES =
        2 * (RESET_CYCLES + 36 * 3 + 11 * (RUN_LIMIT + 2) + QUIET_CYCLES);
    localparam int MODE_RANDOM = 0;
    localparam int MODE_POS    = 1;
    localparam int MODE_NEG    = 2;

    logic                                  clk;
    logic                                  reset_n;
    logic                                  act_write_enable;
    logic [`TILE_WIDTH-1:0]                act_write_data;
    logic [$clog2(`TILE_BUFFER_COUNT)-1:0] act_write_buffer;
    logic                                  wgt_write_enable;
    logic [`TILE_WIDTH-1:0]                wgt_write_data;
    logic [$clog2(`TILE_BUFFER_COUNT)-1:0] wgt_write_buffer;
    logic                                  act_writing_done;
    logic                                  wgt_writing_done;
    logic                                  start;
    op_e                                   op;
    logic [$clog2(`TILE_BUFFER_COUNT)-1:0] act_buffer;
    logic [$clog2(`TILE_BUFFER_COUNT)-1:0] wgt_buffer;
    logic                                  busy;
    logic                                  result_valid;
    acc_t                                  result;

    // Model copy of every buffer, plus the write index of each
    elem_t act_model [`TILE_BUFFER_COUNT][`TILE_COUNT][`TILE_SIZE];
    elem_t wgt_model [`TILE_BUFFER_COUNT][`TILE_COUNT][`TILE_SIZE];
    int    act_windex [`TILE_BUFFER_COUNT] = '{default: 0};
    int    wgt_windex [`TILE_BUFFER_COUNT] = '{default: 0};

    logic [31:0] rng_state = 32'd90707;
    int          error_count = 0;
    int          check_count = 0;
    int          tests_run = 0;
    int          tests_failed = 0;

    tile_engine i_dut (.*);

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    function automatic logic [31:0] next_random();
        rng_state = rng_state ^ (rng_state << 13);
        rng_state = rng_state ^ (rng_state >> 17);
        rng_state = rng_state ^ (rng_state << 5);
        return rng_state;
    endfunction

    function automatic logic [`TILE_WIDTH-1:0] make_tile(input int mode);
        logic [`TILE_WIDTH-1:0] tile;
        logic [31:0]            r;
        elem_t                  mag;
        for (int i = 0; i < `TILE_SIZE; i++) begin
            r   = next_random();
            // Magnitude 1 to 127 keeps every product away from zero
            mag = elem_t'(r[`TILE_DATA_WIDTH-2:0]);
            if (mag == 0) begin
                mag = 1;
            end
            case (mode)
                MODE_POS: tile[i*`TILE_DATA_WIDTH +: `TILE_DATA_WIDTH] = mag;
                MODE_NEG: tile[i*`TILE_DATA_WIDTH +: `TILE_DATA_WIDTH] = -mag;
                default:  tile[i*`TILE_DATA_WIDTH +: `TILE_DATA_WIDTH] = r[31 -: `TILE_DATA_WIDTH];
            endcase
        end
        return tile;
    endfunction

    // Raw dot product of one activation buffer and one weight buffer
    function automatic acc_t expected_sum(input bit ab, input bit wb);
        int sum;
        sum = 0;
        for (int t = 0; t < `TILE_COUNT; t++) begin
            for (int i = 0; i < `TILE_SIZE; i++) begin
                sum = sum + int'(act_model[ab][t][i]) * int'(wgt_model[wb][t][i]);
            end
        end
        return acc_t'(sum);
    endfunction

    task automatic check_result(input string name, input acc_t expected, input acc_t actual);
        check_count++;
        if (actual !== expected) begin
            error_count++;
            $display("ERROR %s: expected %0d, actual %0d", name, expected, actual);
        end
    endtask

    task automatic check_done(input string name, input bit expected, input logic actual);
        check_count++;
        if (actual !== expected) begin
            error_count++;
            $display("ERROR %s: expected %0b, actual %0b", name, expected, actual);
        end
    endtask

    task automatic report_test(input string name, input int mark);
        tests_run++;
        if (error_count == mark) begin
            $display("PASS %s", name);
        end else begin
            tests_failed++;
            $display("FAIL %s with %0d errors", name, error_count - mark);
        end
    endtask

    // Four writes fill one buffer, writing_done marks the last one
    task automatic fill_buffer(input string name, input bit to_wgt, input bit buf_sel,
                               input int mode);
        logic [`TILE_WIDTH-1:0] data;
        int                     idx;
        for (int t = 0; t < `TILE_COUNT; t++) begin
            data = make_tile(mode);
            idx  = to_wgt ? wgt_windex[buf_sel] : act_windex[buf_sel];
            for (int i = 0; i < `TILE_SIZE; i++) begin
                if (to_wgt) begin
                    wgt_model[buf_sel][idx][i] = data[i*`TILE_DATA_WIDTH +: `TILE_DATA_WIDTH];
                end else begin
                    act_model[buf_sel][idx][i] = data[i*`TILE_DATA_WIDTH +: `TILE_DATA_WIDTH];
                end
            end
            @(posedge clk);
            if (to_wgt) begin
                wgt_windex[buf_sel] = (idx + 1) % `TILE_COUNT;
                wgt_write_enable   <= 1'b1;
                wgt_write_data     <= data;
                wgt_write_buffer   <= buf_sel;
            end else begin
                act_windex[buf_sel] = (idx + 1) % `TILE_COUNT;
                act_write_enable   <= 1'b1;
                act_write_data     <= data;
                act_write_buffer   <= buf_sel;
            end
            @(posedge clk);
            act_write_enable <= 1'b0;
            wgt_write_enable <= 1'b0;
            @(negedge clk);
            check_done($sformatf("%s writing_done after tile %0d", name, t),
                       t == `TILE_COUNT - 1, to_wgt ? wgt_writing_done : act_writing_done);
        end
    endtask

    // One run from a start pulse; poke_cycle > 0 pulses start again mid-run
    task automatic run_dot(input string name, input op_e run_op, input bit ab, input bit wb,
                           input int poke_cycle, input acc_t expected);
        bit found;
        found = 1'b0;
        @(posedge clk);
        start      <= 1'b1;
        op         <= run_op;
        act_buffer <= ab;
        wgt_buffer <= wb;
        @(posedge clk);
        start <= 1'b0;
        for (int n = 1; n <= RUN_LIMIT && !found; n++) begin
            @(posedge clk);
            if (n == poke_cycle) begin
                start      <= 1'b1;
                op         <= (run_op == OP_DOT) ? OP_DOT_RELU : OP_DOT;
                act_buffer <= ~ab;
                wgt_buffer <= ~wb;
            end else begin
                start <= 1'b0;
            end
            @(negedge clk);
            if (n < RUN_CYCLES) begin
                check_done({name, " busy during run"}, 1'b1, busy);
                check_done({name, " early result_valid"}, 1'b0, result_valid);
            end else if (n == RUN_CYCLES) begin
                check_done({name, " result_valid on time"}, 1'b1, result_valid);
                check_done({name, " busy released"}, 1'b0, busy);
            end
            if (result_valid === 1'b1) begin
                found = 1'b1;
                check_result(name, expected, result);
            end
        end
        if (!found) begin
            error_count++;
            $display("%s: no result_valid within %0d cycles of start", name, RUN_LIMIT);
        end
    endtask

    task automatic expect_quiet(input string name, input int cycles);
        for (int n = 0; n < cycles; n++) begin
            @(posedge clk);
            @(negedge clk);
            check_done({name, " result_valid"}, 1'b0, result_valid);
            check_done({name, " busy"}, 1'b0, busy);
        end
    endtask

    initial begin
        int mark;
        reset_n          = 1'b0;
        act_write_enable = 1'b0;
        act_write_data   = '0;
        act_write_buffer = '0;
        wgt_write_enable = 1'b0;
        wgt_write_data   = '0;
        wgt_write_buffer = '0;
        start            = 1'b0;
        op               = OP_DOT;
        act_buffer       = '0;
        wgt_buffer       = '0;
        repeat (RESET_CYCLES) @(posedge clk);
        reset_n <= 1'b1;

        mark = error_count;
        @(negedge clk);
        check_done("writes busy after reset", 1'b0, busy);
        check_done("writes result_valid after reset", 1'b0, result_valid);
        for (int b = 0; b < `TILE_BUFFER_COUNT; b++) begin
            fill_buffer($sformatf("writes act%0d", b), 1'b0, 1'(b), MODE_RANDOM);
            fill_buffer($sformatf("writes wgt%0d", b), 1'b1, 1'(b), MODE_RANDOM);
        end
        report_test("writes", mark);

        mark = error_count;
        run_dot("dot", OP_DOT, 1'b0, 1'b0, 0, expected_sum(1'b0, 1'b0));
        report_test("dot", mark);

        // Positive activations against negative weights give a negative sum
        mark = error_count;
        fill_buffer("relu act0", 1'b0, 1'b0, MODE_POS);
        fill_buffer("relu wgt0 negative", 1'b1, 1'b0, MODE_NEG);
        run_dot("relu raw negative", OP_DOT, 1'b0, 1'b0, 0, expected_sum(1'b0, 1'b0));
        run_dot("relu clamped", OP_DOT_RELU, 1'b0, 1'b0, 0, acc_t'(0));
        fill_buffer("relu wgt0 positive", 1'b1, 1'b0, MODE_POS);
        run_dot("relu positive", OP_DOT_RELU, 1'b0, 1'b0, 0, expected_sum(1'b0, 1'b0));
        report_test("relu", mark);

        mark = error_count;
        fork
            run_dot("double buffer 0/0 during refill", OP_DOT, 1'b0, 1'b0, 0,
                    expected_sum(1'b0, 1'b0));
            begin
                fill_buffer("double buffer act1", 1'b0, 1'b1, MODE_RANDOM);
                fill_buffer("double buffer wgt1", 1'b1, 1'b1, MODE_RANDOM);
            end
        join
        for (int p = 0; p < 4; p++) begin
            run_dot($sformatf("double buffer act%0d wgt%0d", p / 2, p % 2), OP_DOT,
                    1'(p / 2), 1'(p % 2), 0, expected_sum(1'(p / 2), 1'(p % 2)));
        end
        report_test("double buffer", mark);

        mark = error_count;
        run_dot("busy second start", OP_DOT, 1'b1, 1'b0, 3, expected_sum(1'b1, 1'b0));
        expect_quiet("busy ignored start", QUIET_CYCLES);
        run_dot("busy next start", OP_DOT, 1'b0, 1'b1, 0, expected_sum(1'b0, 1'b1));
        report_test("busy", mark);

        $display("Summary: %0d tests, %0d failing, %0d compares, %0d errors",
                 tests_run, tests_failed, check_count, error_count);
        if (error_count == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("Timeout: the run did not finish within %0d cycles", WATCHDOG_CYCLES);
        $display("Checks failed");
        $finish;
    end

endmodule

/* tb.f */
+incdir+.
tile_pkg.sv
buffer_file.sv
tile_sequencer.sv
tile_dot_unit.sv
tile_engine.sv
tb_tile_engine.sv

/* Bender.yml */
package:
  name: tile_engine

sources:
  - include_dirs:
      - .
    files:
      - tile_pkg.sv
      - buffer_file.sv
      - tile_sequencer.sv
      - tile_dot_unit.sv
      - tile_engine.sv
  - target: test
    include_dirs:
      - .
    files:
      - tb_tile_engine.sv
